/* design/conv_pkg.sv */
package conv_pkg;

  // element and product widths
  localparam int DATA_W        = 8;
  localparam int PROD_W        = 16;
  localparam int ACC_W_DEFAULT = 28;

  localparam int TAPS       = 9;   // 3x3 window
  localparam int BIAS_SHIFT = 6;   // bias lines up with the accumulator fraction
  localparam int PIXEL_MAX  = 127;

  // start edge to done edge
  localparam int LATENCY = 19;

  typedef logic signed [DATA_W-1:0] elem_t;
  typedef logic signed [PROD_W-1:0] prod_t;

  // tap 0 sits in the top byte
  typedef logic [TAPS*DATA_W-1:0] window_t;

endpackage

/* design/mac_if.sv */
`timescale 1ns/100ps

interface mac_if import conv_pkg::*; #(
  parameter int ACC_W = ACC_W_DEFAULT
) ();

  elem_t            feat;
  elem_t            wght;
  logic             en;     // advances the whole PE pipeline
  logic             first;  // marks tap 0 of a window
  logic [ACC_W-1:0] sum;    // running accumulator

  modport source (
    output feat, wght, en, first,
    input  sum
  );

  modport sink (
    input  feat, wght, en, first,
    output sum
  );

endinterface

/* design/cla_block4.sv */
`timescale 1ns/100ps

module cla_block4 (
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic       cin,
  output logic [3:0] s,
  output logic       pg,
  output logic       gg
);

  logic [3:0] p;  // bit propagate
  logic [3:0] g;  // bit generate
  logic [3:0] c;  // carry into each bit

  assign p = a ^ b;
  assign g = a & b;

  // carries inside the slice
  assign c[0] = cin;
  assign c[1] = g[0] | (p[0] & c[0]);
  assign c[2] = g[1] | (p[1] & c[1]);
  assign c[3] = g[2] | (p[2] & c[2]);

  assign s = p ^ c;

  // group terms for the next lookahead level
  assign pg = &p;
  assign gg = g[3]
            | (p[3] & g[2])
            | (p[3] & p[2] & g[1])
            | (p[3] & p[2] & p[1] & g[0]);

endmodule

/* design/cla_adder.sv */
`timescale 1ns/100ps

module cla_adder #(
  parameter int WIDTH = 28   // multiple of 4
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] s
);

  localparam int NG = WIDTH / 4;  // number of 4-bit groups

  logic [NG-1:0] grp_p;
  logic [NG-1:0] grp_g;
  logic [NG-1:0] grp_c;  // carry into each group

  assign grp_c[0] = 1'b0;  // plain add, carry-in tied off

  for (genvar i = 0; i < NG; i++) begin : g_slice
    cla_block4 u_blk (
      .a   (a[4*i +: 4]),
      .b   (b[4*i +: 4]),
      .cin (grp_c[i]),
      .s   (s[4*i +: 4]),
      .pg  (grp_p[i]),
      .gg  (grp_g[i])
    );

    // group lookahead chain, carry out of the top group is dropped
    if (i < NG - 1) begin : g_carry
      assign grp_c[i+1] = grp_g[i] | (grp_p[i] & grp_c[i]);
    end
  end

endmodule

/* design/mult_pipe.sv */
`timescale 1ns/100ps

module mult_pipe import conv_pkg::*; (
  input  logic  clk,
  input  logic  en,
  input  elem_t a,
  input  elem_t b,
  input  logic  first_in,
  output prod_t p,
  output logic  first_out
);

  logic [DATA_W-1:0] a_mag;
  logic [DATA_W-1:0] b_mag;
  logic [7:1]        sign_q;    // product sign, stages 1 to 7
  logic [8:1]        first_q;   // first flag, stages 1 to 8

  logic [DATA_W-1:0] pp_q [8];        // gated partial products
  logic [5:0]        lsb2_q [4];
  logic [2:0]        lo_hi2_q [4];    // even pp bits 7:5
  logic [3:0]        hi_hi2_q [4];    // odd pp bits 7:4
  logic [4:0]        msb3 [4];
  logic [9:0]        sum3_q [4];
  logic [7:0]        lsb4_q [2];
  logic [2:0]        lo_hi4_q [2];
  logic [4:0]        hi_hi4_q [2];
  logic [4:0]        msb5 [2];
  logic [11:0]       sum5_q [2];
  logic [9:0]        lsb6_q;
  logic [2:0]        lo_hi6_q;
  logic [6:0]        hi_hi6_q;
  logic [6:0]        msb7;
  logic [15:0]       mag_q;           // unsigned product

  assign a_mag = a[DATA_W-1] ? -a : a;
  assign b_mag = b[DATA_W-1] ? -b : b;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1: partial products on the magnitudes
  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < 8; i++) begin
        pp_q[i] <= b_mag[i] ? a_mag : '0;
      end
      sign_q[1]  <= a[DATA_W-1] ^ b[DATA_W-1];
      first_q[1] <= first_in;
    end
  end

  // stage 2: low halves of each pp pair, odd one weighted by 2
  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < 4; i++) begin
        lsb2_q[i]   <= 6'(pp_q[2*i][4:0]) + 6'({pp_q[2*i+1][3:0], 1'b0});
        lo_hi2_q[i] <= pp_q[2*i][7:5];
        hi_hi2_q[i] <= pp_q[2*i+1][7:4];
      end
    end
  end

  // stage 3: high halves plus the carry out of stage 2
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      msb3[i] = 5'(lo_hi2_q[i]) + 5'(hi_hi2_q[i]) + 5'(lsb2_q[i][5]);
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < 4; i++) begin
        sum3_q[i] <= {msb3[i], lsb2_q[i][4:0]};
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 4: pair sums combined at shift 2, low part
  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < 2; i++) begin
        lsb4_q[i]   <= 8'(sum3_q[2*i][6:0]) + 8'({sum3_q[2*i+1][4:0], 2'b00});
        lo_hi4_q[i] <= sum3_q[2*i][9:7];
        hi_hi4_q[i] <= sum3_q[2*i+1][9:5];
      end
    end
  end

  // stage 5: high part at shift 2
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      msb5[i] = 5'(lo_hi4_q[i]) + hi_hi4_q[i] + 5'(lsb4_q[i][7]);
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < 2; i++) begin
        sum5_q[i] <= {msb5[i], lsb4_q[i][6:0]};
      end
    end
  end

  // stage 6: final pair at shift 4, low part
  always_ff @(posedge clk) begin
    if (en) begin
      lsb6_q   <= 10'(sum5_q[0][8:0]) + 10'({sum5_q[1][4:0], 4'b0000});
      lo_hi6_q <= sum5_q[0][11:9];
      hi_hi6_q <= sum5_q[1][11:5];
    end
  end

  // stage 7
  assign msb7 = 7'(lo_hi6_q) + hi_hi6_q + 7'(lsb6_q[9]);

  always_ff @(posedge clk) begin
    if (en) begin
      mag_q <= {msb7, lsb6_q[8:0]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 8: put the sign back
  always_ff @(posedge clk) begin
    if (en) begin
      p <= sign_q[7] ? prod_t'(~mag_q + 16'd1) : prod_t'(mag_q);
    end
  end

  // side flags follow the data one stage at a time
  always_ff @(posedge clk) begin
    if (en) begin
      sign_q[7:2]  <= sign_q[6:1];
      first_q[8:2] <= first_q[7:1];
    end
  end

  assign first_out = first_q[8];

endmodule

/* design/mac_pe.sv */
`timescale 1ns/100ps

module mac_pe import conv_pkg::*; #(
  parameter int ACC_W = ACC_W_DEFAULT
) (
  input logic clk,
  mac_if.sink m
);

  prod_t            prod;
  logic             prod_first;  // first flag lined up with prod
  logic [ACC_W-1:0] acc;
  logic [ACC_W-1:0] acc_base;
  logic [ACC_W-1:0] acc_next;

  mult_pipe u_mult (
    .clk       (clk),
    .en        (m.en),
    .a         (m.feat),
    .b         (m.wght),
    .first_in  (m.first),
    .p         (prod),
    .first_out (prod_first)
  );

  // tap 0 starts a fresh sum
  assign acc_base = prod_first ? '0 : acc;

  cla_adder #(.WIDTH(ACC_W)) u_acc_add (
    .a ({{(ACC_W-PROD_W){prod[PROD_W-1]}}, prod}),
    .b (acc_base),
    .s (acc_next)
  );

  always_ff @(posedge clk) begin
    if (m.en) begin
      acc <= acc_next;
    end
  end

  assign m.sum = acc;

endmodule

/* design/window_sequencer.sv */
`timescale 1ns/100ps

module window_sequencer import conv_pkg::*; (
  input  logic    clk,
  input  logic    rstn,
  input  logic    start,
  input  window_t feat_win,
  input  window_t wght_win,
  input  elem_t   bias_in,
  mac_if.source   m,
  output elem_t   bias,
  output logic    fire
);

  // count at the edge that raises fire, start edge counted as 0
  localparam int LAST_CNT = LATENCY - 2;

  logic       busy;
  logic [4:0] cnt;
  window_t    feat_sr;
  window_t    wght_sr;

  ////////////////////////////////////////////////////////////////////////////
  // control
  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy    <= 1'b0;
      cnt     <= '0;
      m.en    <= 1'b0;
      m.first <= 1'b0;
      fire    <= 1'b0;
    end else begin
      fire    <= 1'b0;
      m.first <= 1'b0;
      if (!busy) begin
        if (start) begin  // a start while busy falls through and is lost
          busy <= 1'b1;
          cnt  <= '0;
        end
      end else begin
        cnt <= cnt + 5'd1;
        if (cnt == 5'd0) begin
          m.en    <= 1'b1;
          m.first <= 1'b1;  // goes out with tap 0
        end
        if (cnt == 5'(LAST_CNT)) begin
          busy <= 1'b0;
          m.en <= 1'b0;
          fire <= 1'b1;     // accumulator now holds tap 8
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // window capture and tap shifting
  always_ff @(posedge clk) begin
    if (!busy && start) begin
      feat_sr <= feat_win;
      wght_sr <= wght_win;
      bias    <= bias_in;
    end else if (busy) begin
      m.feat  <= feat_sr[TAPS*DATA_W-1 -: DATA_W];
      m.wght  <= wght_sr[TAPS*DATA_W-1 -: DATA_W];
      feat_sr <= feat_sr << DATA_W;  // zeros follow the last tap
      wght_sr <= wght_sr << DATA_W;
    end
  end

endmodule

/* design/requant_stage.sv */
`timescale 1ns/100ps

module requant_stage import conv_pkg::*; #(
  parameter int ACC_W = ACC_W_DEFAULT
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              fire,
  input  logic [ACC_W-1:0]  sum,
  input  elem_t             bias,
  output logic [DATA_W-1:0] pixel,
  output logic [ACC_W-1:0]  mac_sum,
  output logic              done
);

  localparam int EXT_W   = ACC_W - DATA_W - BIAS_SHIFT;
  localparam int PIX_LSB = BIAS_SHIFT;
  localparam int PIX_MSB = BIAS_SHIFT + DATA_W - 2;  // 7 magnitude bits

  logic [ACC_W-1:0]  bias_al;
  logic [ACC_W-1:0]  biased;
  logic              sat;
  logic [DATA_W-1:0] pixel_d;

  assign bias_al = {{EXT_W{bias[DATA_W-1]}}, bias, {BIAS_SHIFT{1'b0}}};

  cla_adder #(.WIDTH(ACC_W)) u_bias_add (
    .a (sum),
    .b (bias_al),
    .s (biased)
  );

  assign sat = |biased[ACC_W-2:PIX_MSB+1];  // too big for 7 bits

  always_comb begin
    if (biased[ACC_W-1]) begin
      pixel_d = '0;                       // negative clamps to zero
    end else if (sat) begin
      pixel_d = DATA_W'(PIXEL_MAX);
    end else begin
      pixel_d = {1'b0, biased[PIX_MSB:PIX_LSB]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pixel   <= '0;
      mac_sum <= '0;
      done    <= 1'b0;
    end else begin
      done <= fire;
      if (fire) begin
        pixel   <= pixel_d;
        mac_sum <= sum;
      end
    end
  end

endmodule

/* design/conv_window_top.sv */
`timescale 1ns/100ps

module conv_window_top import conv_pkg::*; #(
  parameter int ACC_W = ACC_W_DEFAULT
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              start,
  input  window_t           feat_win,
  input  window_t           wght_win,
  input  elem_t             bias_in,
  output logic [DATA_W-1:0] pixel,
  output logic [ACC_W-1:0]  mac_sum,
  output logic              done
);

  elem_t bias;
  logic  fire;  // window sum complete

  mac_if #(.ACC_W(ACC_W)) u_mac_if ();

  window_sequencer u_seq (
    .clk      (clk),
    .rstn     (rstn),
    .start    (start),
    .feat_win (feat_win),
    .wght_win (wght_win),
    .bias_in  (bias_in),
    .m        (u_mac_if.source),
    .bias     (bias),
    .fire     (fire)
  );

  mac_pe #(.ACC_W(ACC_W)) u_pe (
    .clk (clk),
    .m   (u_mac_if.sink)
  );

  requant_stage #(.ACC_W(ACC_W)) u_requant (
    .clk     (clk),
    .rstn    (rstn),
    .fire    (fire),
    .sum     (u_mac_if.sum),
    .bias    (bias),
    .pixel   (pixel),
    .mac_sum (mac_sum),
    .done    (done)
  );

endmodule

/* tb/tb_conv_window.sv */
`timescale 1ns/100ps

module tb_conv_window import conv_pkg::*; ();

  localparam int ACC_W      = ACC_W_DEFAULT;
  localparam int N_RANDOM   = 40;
  localparam int MAX_CYCLES = 60 * (LATENCY + 4) + 200;

  logic              clk;
  logic              rstn;
  logic              start;
  window_t           feat_win;
  window_t           wght_win;
  elem_t             bias_in;
  logic [DATA_W-1:0] pixel;
  logic [ACC_W-1:0]  mac_sum;
  logic              done;

  integer seed = 32'haffc;
  int     cycles = 0;
  int     tests_run = 0;
  int     tests_bad = 0;

  conv_window_top #(.ACC_W(ACC_W)) UUT (
    .clk      (clk),
    .rstn     (rstn),
    .start    (start),
    .feat_win (feat_win),
    .wght_win (wght_win),
    .bias_in  (bias_in),
    .pixel    (pixel),
    .mac_sum  (mac_sum),
    .done     (done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // hard stop if something never finishes
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run went past %0d clock cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  // signed dot product of the two windows, wrapped to the accumulator width
  function automatic logic [ACC_W-1:0] model_sum(input window_t f, input window_t w);
    longint acc;
    elem_t  fe;
    elem_t  we;
    acc = 0;
    for (int i = 0; i < TAPS; i++) begin
      fe = f[(TAPS-1-i)*DATA_W +: DATA_W];  // tap 0 in the top byte
      we = w[(TAPS-1-i)*DATA_W +: DATA_W];
      acc += longint'(fe) * longint'(we);
    end
    return acc[ACC_W-1:0];
  endfunction

  function automatic logic [DATA_W-1:0] model_pixel(input logic [ACC_W-1:0] s, input elem_t b);
    longint v;
    v = {{(64-ACC_W){s[ACC_W-1]}}, s};
    v = v + longint'(b) * (longint'(1) << BIAS_SHIFT);
    v = (v <<< (64 - ACC_W)) >>> (64 - ACC_W);  // wrap to ACC_W, keep sign
    if (v < 0) begin
      return '0;
    end else if (v >= (longint'(PIXEL_MAX) + 1) << BIAS_SHIFT) begin
      return DATA_W'(PIXEL_MAX);
    end
    return DATA_W'(v >> BIAS_SHIFT);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic tick();
    @(posedge clk);
    #2;  // drive and sample away from the edge
  endtask

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what,
                       output int bad);
    bad = 0;
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      bad = 1;
    end
  endtask

  task automatic rand_window(output window_t w);
    for (int i = 0; i < TAPS; i++) begin
      w[i*DATA_W +: DATA_W] = $random(seed);
    end
  endtask

  // n counts cycles since the edge that sampled start
  task automatic wait_done(inout int n, output int bad);
    while (done !== 1'b1 && n < LATENCY + 8) begin
      tick();
      n++;
    end
    if (done !== 1'b1) begin
      $display("done never came, waited %0d cycles after start", n);
      bad = 1;
    end else begin
      check(n, LATENCY, "done latency", bad);
    end
  endtask

  task automatic run_window(input window_t f, input window_t w, input elem_t b,
                            output logic [ACC_W-1:0] s_got, output logic [DATA_W-1:0] p_got,
                            output int bad);
    int n;
    int b1;
    feat_win = f;
    wght_win = w;
    bias_in  = b;
    start    = 1'b1;
    tick();
    start    = 1'b0;
    feat_win = ~f;  // window must already be captured
    wght_win = ~w;
    bias_in  = ~b;
    n = 0;
    wait_done(n, bad);
    s_got = mac_sum;
    p_got = pixel;
    tick();
    check(done, 1'b0, "done pulse width", b1);
    bad += b1;
  endtask

  task automatic report(input int num, input string name, input int bad);
    tests_run++;
    if (bad != 0) tests_bad++;
    $display("test %0d %s: %s", num, name, (bad != 0) ? "FAIL" : "ok");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  initial begin
    window_t           f;
    window_t           w;
    window_t           fb;
    window_t           wb;
    elem_t             b;
    elem_t             bb;
    logic [ACC_W-1:0]  s_got;
    logic [DATA_W-1:0] p_got;
    logic [ACC_W-1:0]  s_exp;
    int                bad;
    int                b1;
    int                sum_bad;
    int                pix_bad;
    int                lat_bad;
    int                n;
    int                extra;

    rstn     = 1'b0;
    start    = 1'b0;
    feat_win = '0;
    wght_win = '0;
    bias_in  = '0;
    repeat (5) @(posedge clk);
    #2;
    rstn = 1'b1;

    // 1: quiet outputs before any start
    bad = 0;
    repeat (10) begin
      tick();
      check(done, 1'b0, "done while idle", b1);
      bad += b1;
      check(pixel, 0, "pixel while idle", b1);
      bad += b1;
      check(mac_sum, 0, "mac_sum while idle", b1);
      bad += b1;
    end
    report(1, "idle after reset", bad);

    // 2 to 4: random windows, then the two saturation corners
    sum_bad = 0;
    pix_bad = 0;
    lat_bad = 0;
    for (int k = 0; k < N_RANDOM + 2; k++) begin
      if (k < N_RANDOM) begin
        rand_window(f);
        rand_window(w);
        b = $random(seed);
      end else if (k == N_RANDOM) begin
        f = {TAPS{8'h80}};
        w = {TAPS{8'h80}};
        b = 8'sd127;
      end else begin
        f = {TAPS{8'h7f}};
        w = {TAPS{8'h80}};
        b = $random(seed);
      end
      run_window(f, w, b, s_got, p_got, bad);
      lat_bad += bad;
      s_exp = model_sum(f, w);
      check(s_got, s_exp, "mac_sum", b1);
      sum_bad += b1;
      check(p_got, model_pixel(s_exp, b), "pixel", b1);
      pix_bad += b1;
      if (k == N_RANDOM) begin
        check(p_got, PIXEL_MAX, "pixel at positive clamp", b1);
        pix_bad += b1;
      end else if (k == N_RANDOM + 1) begin
        check(p_got, 0, "pixel at negative clamp", b1);
        pix_bad += b1;
      end
    end
    report(2, "window sums", sum_bad);
    report(3, "requantized pixels", pix_bad);
    report(4, "done latency and width", lat_bad);

    // 5: start during a busy window is dropped
    bad = 0;
    rand_window(f);
    rand_window(w);
    b = $random(seed);
    rand_window(fb);
    rand_window(wb);
    bb = $random(seed);
    feat_win = f;
    wght_win = w;
    bias_in  = b;
    start    = 1'b1;
    tick();
    start = 1'b0;
    n = 0;
    repeat (4) begin
      tick();
      n++;
    end
    feat_win = fb;
    wght_win = wb;
    bias_in  = bb;
    start    = 1'b1;
    tick();  // second start sampled 5 cycles after the first
    n++;
    start = 1'b0;
    wait_done(n, b1);
    bad += b1;
    s_exp = model_sum(f, w);
    check(mac_sum, s_exp, "mac_sum after dropped start", b1);
    bad += b1;
    check(pixel, model_pixel(s_exp, b), "pixel after dropped start", b1);
    bad += b1;
    extra = 0;
    repeat (LATENCY + 6) begin
      tick();
      if (done === 1'b1) extra++;
    end
    check(extra, 0, "done pulses from dropped start", b1);
    bad += b1;
    report(5, "start while busy", bad);

    $display("summary: %0d tests run, %0d passed, %0d failed",
             tests_run, tests_run - tests_bad, tests_bad);
    if (tests_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* sources.f */
design/conv_pkg.sv
design/mac_if.sv
design/cla_block4.sv
design/cla_adder.sv
design/mult_pipe.sv
design/mac_pe.sv
design/window_sequencer.sv
design/requant_stage.sv
design/conv_window_top.sv
tb/tb_conv_window.sv
